// ==== tests/mulDiv_stim.txt ====
// kind (0 mul, 1 div) operandA operandB rdIn expectedResult expectedException
// any other kind ends the list
0 00000003 00000007 01 00000015 0
0 fffffffd 00000007 02 ffffffeb 0
0 fffffffb fffffffa 03 0000001e 0
0 00010000 00010000 04 00000000 1
0 40000000 00000002 00 80000000 1
0 80000000 00000001 1f 80000000 0
0 80000000 ffffffff 05 80000000 1
0 7fffffff 7fffffff 06 00000001 1
0 00000000 ffffffff 07 00000000 0
0 12345678 ffffffff 08 edcba988 0
1 00000064 00000007 09 0000000e 0
1 ffffff9c 00000007 0a fffffff2 0
1 00000064 fffffff9 0b fffffff2 0
1 ffffff9c fffffff9 0c 0000000e 0
1 00000005 00000000 00 00000000 1
1 80000000 ffffffff 0d 80000000 0
1 00000007 00000064 0e 00000000 0
1 80000000 00000002 1e c0000000 0
ff

// ==== verilog.f ====
+incdir+src
src/mulDivPkg.sv
src/mulDivIf.sv
src/hazardScoreboard.sv
src/iterativeMulDiv.sv
src/resultFormat.sv
src/mulDivHazardUnit.sv
tests/mulDivHazardUnit_sva.sv
tests/mulDivHazardUnit_tb.sv

// ==== Makefile ====
# Verilator flow for the mul/div hazard unit
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
FILELIST ?= verilog.f
TOP ?= mulDivHazardUnit_tb
RTL_TOP ?= mulDivHazardUnit
BUILD_DIR ?= obj_dir
JOBS ?= 0
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS ?= --binary --timing --assert -j $(JOBS)
RUN_ARGS ?=

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits nonzero on $fatal or a failed assertion
sim: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/mulDivHazardUnit_tb.sv ====
`timescale 1ns/1ps
`include "mulDiv_consts.svh"

module mulDivHazardUnit_tb import mulDivPkg::*; ();

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int TIMEOUT_CYCLES = 100;
	localparam int QUIET_CYCLES = 40;
	localparam int MAX_VECS = 64;
	localparam int VEC_WORDS = 6;
	localparam int BUSY_REQ_EDGE = 5;
	localparam string STIM_FILE = "tests/mulDiv_stim.txt";

	logic clock;
	logic rst;
	logic ctrlMult;
	logic ctrlDiv;
	word_t operandA;
	word_t operandB;
	regAddr_t rdIn;
	regAddr_t rs1;
	regAddr_t rs2;
	regAddr_t rd;
	word_t result;
	logic exception;
	logic resultRdy;
	logic stall;

	logic [31:0] stim [0:MAX_VECS*VEC_WORDS-1];
	integer seed;
	int vecCount;
	int hazardHits;

	mulDivHazardUnit uut (
		.clock(clock),
		.rst(rst),
		.ctrlMult(ctrlMult),
		.ctrlDiv(ctrlDiv),
		.operandA(operandA),
		.operandB(operandB),
		.rdIn(rdIn),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.result(result),
		.exception(exception),
		.resultRdy(resultRdy),
		.stall(stall)
	);

	always #(PERIOD/2) clock = ~clock;

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "run aborted");
	endtask

	// One pending cycle: random decode registers, a busy request at one edge
	task automatic probeStall(input int edgeNum, input regAddr_t dest, input logic isMul);
		logic [31:0] r;
		logic request;
		logic hit;
		logic expStall;
		r = $random(seed);
		request = (edgeNum == BUSY_REQ_EDGE);
		// Ask for the other kind so an accepted start would change the result
		ctrlMult = request & ~isMul;
		ctrlDiv = request & isMul;
		operandA = $random(seed);
		operandB = $random(seed);
		rdIn = regAddr_t'($random(seed));
		rs1 = (r[1:0] == 2'd0) ? dest : regAddr_t'($random(seed));
		rs2 = (r[3:2] == 2'd0) ? dest : regAddr_t'($random(seed));
		rd = (r[5:4] == 2'd0) ? dest : regAddr_t'($random(seed));
		#1;
		hit = (dest != '0) && ((rs1 == dest) || (rs2 == dest) || (rd == dest));
		expStall = (edgeNum < `MULDIV_LATENCY) && (request || hit);
		if (hit) begin
			hazardHits++;
		end
		check($sformatf("stall after edge %0d", edgeNum), 64'(expStall), 64'(stall));
	endtask

	// Entered and left on a falling edge with the unit idle
	task automatic runVector(input int idx);
		int base;
		int edges;
		logic isMul;
		logic seen;
		logic expExc;
		regAddr_t dest;
		word_t expResult;
		string name;
		base = idx * VEC_WORDS;
		isMul = (stim[base] == 32'd0);
		dest = regAddr_t'(stim[base + 3]);
		expResult = stim[base + 4];
		expExc = stim[base + 5][0];
		name = $sformatf("vec%0d %s", idx, isMul ? "mul" : "div");
		ctrlMult = isMul;
		ctrlDiv = ~isMul;
		operandA = stim[base + 1];
		operandB = stim[base + 2];
		rdIn = dest;
		rs1 = dest;
		rs2 = dest;
		rd = dest;
		#1;
		check({name, " idle stall"}, 64'(0), 64'(stall));
		@(posedge clock);
		edges = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clock);
			if (resultRdy) begin
				seen = 1'b1;
			end else if (edges >= TIMEOUT_CYCLES) begin
				abortRun($sformatf("the result of %s never arrived within %0d cycles",
					name, TIMEOUT_CYCLES));
			end else begin
				probeStall(edges, dest, isMul);
				@(posedge clock);
				edges++;
			end
		end
		check({name, " latency"}, 64'(`MULDIV_LATENCY), 64'(edges));
		check({name, " result"}, 64'(expResult), 64'(result));
		check({name, " exception"}, 64'(expExc), 64'(exception));
		check({name, " stall at retire"}, 64'(0), 64'(stall));
	endtask

	initial begin
		clock = 1'b0;
		rst = 1'b1;
		ctrlMult = 1'b0;
		ctrlDiv = 1'b0;
		operandA = '0;
		operandB = '0;
		rdIn = '0;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		seed = 61;
		vecCount = 0;
		hazardHits = 0;

		// A missing file leaves no valid kind word
		for (int i = 0; i < MAX_VECS*VEC_WORDS; i++) begin
			stim[i] = 32'hdead0000 ^ 32'(i);
		end
		$readmemh(STIM_FILE, stim);

		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		#1;
		check("reset resultRdy", 64'(0), 64'(resultRdy));
		check("reset exception", 64'(0), 64'(exception));
		check("reset stall", 64'(0), 64'(stall));

		// Back to back, each start lands in the previous resultRdy cycle
		@(negedge clock);
		while (vecCount < MAX_VECS && stim[vecCount*VEC_WORDS] <= 32'd1) begin
			runVector(vecCount);
			vecCount++;
		end

		// Single pulse, and the rejected request never completes
		ctrlMult = 1'b0;
		ctrlDiv = 1'b0;
		repeat (QUIET_CYCLES) begin
			@(negedge clock);
			rs1 = regAddr_t'($random(seed));
			rs2 = regAddr_t'($random(seed));
			rd = regAddr_t'($random(seed));
			#1;
			check("quiet resultRdy", 64'(0), 64'(resultRdy));
			check("quiet stall", 64'(0), 64'(stall));
		end

		if (vecCount == 0) begin
			$display("no vectors were read from %s", STIM_FILE);
			$display("sim failed");
			$fatal(1, "empty stimulus");
		end else if (hazardHits == 0) begin
			$display("no data hazard was exercised");
			$display("sim failed");
			$fatal(1, "hazard not covered");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// ==== tests/mulDivHazardUnit_sva.sv ====
`timescale 1ns/1ps

module mulDivHazardUnit_sva (
	input logic clock,
	input logic rst,
	input logic pending,
	input logic stall,
	input logic retire
);

	// retire is the resultRdy register itself
	property singleResultPulse;
		@(posedge clock) disable iff (rst)
			retire |=> !retire;
	endproperty

	property retireNeedsPending;
		@(posedge clock) disable iff (rst)
			retire |-> $past(pending);
	endproperty

	// Pending drops with done one cycle before the old destination clears
	property idleNoStall;
		@(posedge clock) disable iff (rst)
			retire |-> !stall;
	endproperty

	resultPulse: assert property (singleResultPulse)
		else $error("resultRdy high for two consecutive cycles");

	retirePending: assert property (retireNeedsPending)
		else $error("retire without a pending operation");

	idleStall: assert property (idleNoStall)
		else $error("stall raised while nothing is pending");

endmodule

bind hazardScoreboard mulDivHazardUnit_sva scoreboardChecks (
	.clock(clock),
	.rst(rst),
	.pending(pending),
	.stall(stall),
	.retire(bus.retire)
);

// ==== src/mulDivHazardUnit.sv ====
`timescale 1ns/1ps

module mulDivHazardUnit import mulDivPkg::*; (
	input logic clock,
	input logic rst,
	input logic ctrlMult,
	input logic ctrlDiv,
	input word_t operandA,
	input word_t operandB,
	input regAddr_t rdIn,
	input regAddr_t rs1,
	input regAddr_t rs2,
	input regAddr_t rd,
	output word_t result,
	output logic exception,
	output logic resultRdy,
	output logic stall
);

	mulDivIf bus ();

	// Issue, pending destination and decode stall
	hazardScoreboard scoreboard (
		.clock(clock),
		.rst(rst),
		.ctrlMult(ctrlMult),
		.ctrlDiv(ctrlDiv),
		.operandA(operandA),
		.operandB(operandB),
		.rdIn(rdIn),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.stall(stall),
		.bus(bus.scoreboard)
	);

	iterativeMulDiv datapath (
		.clock(clock),
		.rst(rst),
		.bus(bus.datapath)
	);

	// Sign fixup and exceptions
	resultFormat formatter (
		.clock(clock),
		.rst(rst),
		.bus(bus.result),
		.result(result),
		.exception(exception),
		.resultRdy(resultRdy)
	);

endmodule

// ==== src/resultFormat.sv ====
`timescale 1ns/1ps
`include "mulDiv_consts.svh"

module resultFormat import mulDivPkg::*; (
	input logic clock,
	input logic rst,
	mulDivIf.result bus,
	output word_t result,
	output logic exception,
	output logic resultRdy
);

	localparam int W = `WORD_W;

	logic negate;
	dword_t signedProduct;
	logic mulOverflow;
	word_t quotient;
	word_t signedQuotient;
	word_t resultNext;
	logic excNext;

	// Result is negative when exactly one operand was
	assign negate = bus.signA ^ bus.signB;

	assign signedProduct = negate ? -bus.magResult : bus.magResult;

	// Upper word must be a pure sign extension of the low word
	assign mulOverflow = signedProduct != {{W{signedProduct[W-1]}}, signedProduct[W-1:0]};

	// MIN / -1 wraps back to MIN here
	assign quotient = bus.magResult[W-1:0];
	assign signedQuotient = negate ? -quotient : quotient;

	always_comb begin
		if (bus.kind == OP_MUL) begin
			resultNext = signedProduct[W-1:0];
			excNext = mulOverflow;
		end else if (bus.divZero) begin
			resultNext = '0;
			excNext = 1'b1;
		end else begin
			resultNext = signedQuotient;
			excNext = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			resultRdy <= 1'b0;
			exception <= 1'b0;
		end else begin
			resultRdy <= bus.done;
			exception <= bus.done & excNext;
		end
	end

	// Result word holds until the next completion
	always_ff @(posedge clock) begin
		if (bus.done) begin
			result <= resultNext;
		end
	end

	assign bus.retire = resultRdy;

endmodule

// ==== src/iterativeMulDiv.sv ====
`timescale 1ns/1ps
`include "mulDiv_consts.svh"

module iterativeMulDiv import mulDivPkg::*; (
	input logic clock,
	input logic rst,
	mulDivIf.datapath bus
);

	localparam int W = `WORD_W;
	localparam int CNT_W = $clog2(`MULDIV_ITERS);
	localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MULDIV_ITERS - 1);

	logic busy;
	logic [CNT_W-1:0] count;
	opKind_t kind;
	word_t operand;
	dword_t work;
	opKind_t stepKind;
	word_t stepOperand;
	dword_t stepIn;
	dword_t nextWork;

	// Shift-add, upper half accumulates, multiplier drains from the bottom
	function automatic dword_t mulStep(dword_t acc, word_t mcand);
		logic [W:0] sum;
		sum = {1'b0, acc[2*W-1:W]} + (acc[0] ? {1'b0, mcand} : '0);
		return {sum, acc[W-1:1]};
	endfunction

	// Restoring step, remainder on top and quotient bits shifted in below
	function automatic dword_t divStep(dword_t acc, word_t divisor);
		logic [W:0] shifted;
		logic [W:0] trial;
		shifted = acc[2*W-1:W-1];
		trial = shifted - {1'b0, divisor};
		if (trial[W]) begin
			return {shifted[W-1:0], acc[W-2:0], 1'b0};
		end
		return {trial[W-1:0], acc[W-2:0], 1'b1};
	endfunction

	// First iteration runs straight off the bus in the start cycle
	always_comb begin
		if (bus.start) begin
			stepKind = bus.kind;
			if (bus.kind == OP_MUL) begin
				stepOperand = bus.a;
				stepIn = {{W{1'b0}}, bus.b};
			end else begin
				stepOperand = bus.b;
				stepIn = {{W{1'b0}}, bus.a};
			end
		end else begin
			stepKind = kind;
			stepOperand = operand;
			stepIn = work;
		end
	end

	always_comb begin
		if (stepKind == OP_MUL) begin
			nextWork = mulStep(stepIn, stepOperand);
		end else begin
			nextWork = divStep(stepIn, stepOperand);
		end
	end

	// Iteration counter and done pulse
	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			count <= '0;
			bus.done <= 1'b0;
		end else begin
			bus.done <= 1'b0;
			if (bus.start) begin
				busy <= 1'b1;
				count <= CNT_W'(1);
			end else if (busy) begin
				count <= count + 1'b1;
				if (count == LAST_STEP) begin
					busy <= 1'b0;
					bus.done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (bus.start) begin
			kind <= bus.kind;
			operand <= stepOperand;
			bus.divZero <= (bus.kind == OP_DIV) && (bus.b == '0);
		end
		if (bus.start | busy) begin
			work <= nextWork;
		end
	end

	// Product for multiply, quotient in the low word for divide
	assign bus.magResult = work;

endmodule

// ==== src/hazardScoreboard.sv ====
`timescale 1ns/1ps
`include "mulDiv_consts.svh"

module hazardScoreboard import mulDivPkg::*; (
	input logic clock,
	input logic rst,
	input logic ctrlMult,
	input logic ctrlDiv,
	input word_t operandA,
	input word_t operandB,
	input regAddr_t rdIn,
	input regAddr_t rs1,
	input regAddr_t rs2,
	input regAddr_t rd,
	output logic stall,
	mulDivIf.scoreboard bus
);

	localparam int W = `WORD_W;

	logic startReq;
	logic accept;
	logic pending;
	logic issued;
	regAddr_t pendingDest;
	opKind_t issueKind;
	word_t issueA;
	word_t issueB;
	logic destHit;
	logic dataHazard;
	logic busyHazard;

	assign startReq = ctrlMult | ctrlDiv;
	assign accept = startReq & ~pending;

	// Busy from the accepting edge until the datapath finishes
	always_ff @(posedge clock) begin
		if (rst) begin
			pending <= 1'b0;
			issued <= 1'b0;
		end else begin
			issued <= accept;
			if (accept) begin
				pending <= 1'b1;
			end else if (bus.done) begin
				pending <= 1'b0;
			end
		end
	end

	// Destination is held until the result retires
	always_ff @(posedge clock) begin
		if (rst) begin
			pendingDest <= '0;
		end else if (accept) begin
			pendingDest <= rdIn;
		end else if (bus.retire) begin
			pendingDest <= '0;
		end
	end

	// Multiply has priority when both requests are up
	always_ff @(posedge clock) begin
		if (accept) begin
			issueKind <= ctrlMult ? OP_MUL : OP_DIV;
			issueA <= operandA;
			issueB <= operandB;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			bus.start <= 1'b0;
		end else begin
			bus.start <= issued;
		end
	end

	// Split operands into sign and magnitude for the datapath
	always_ff @(posedge clock) begin
		if (issued) begin
			bus.kind <= issueKind;
			bus.signA <= issueA[W-1];
			bus.signB <= issueB[W-1];
			bus.a <= issueA[W-1] ? -issueA : issueA;
			bus.b <= issueB[W-1] ? -issueB : issueB;
		end
	end

	assign destHit = (rs1 == pendingDest) | (rs2 == pendingDest) | (rd == pendingDest);

	// Writes to r0 are never a hazard
	assign dataHazard = pending & (pendingDest != '0) & destHit;
	assign busyHazard = pending & startReq;
	assign stall = dataHazard | busyHazard;

endmodule

// ==== src/mulDivIf.sv ====
`timescale 1ns/1ps

interface mulDivIf
	import mulDivPkg::*;
();

	// Issue from scoreboard
	logic start;
	opKind_t kind;
	word_t a;
	word_t b;
	logic signA;
	logic signB;

	// Datapath completion
	logic done;
	dword_t magResult;
	logic divZero;

	// Result leaves the unit
	logic retire;

	modport scoreboard (
		output start,
		output kind,
		output a,
		output b,
		output signA,
		output signB,
		input done,
		input retire
	);

	modport datapath (
		input start,
		input kind,
		input a,
		input b,
		output done,
		output magResult,
		output divZero
	);

	modport result (
		input kind,
		input signA,
		input signB,
		input done,
		input magResult,
		input divZero,
		output retire
	);

endinterface

// ==== src/mulDivPkg.sv ====
`include "mulDiv_consts.svh"

package mulDivPkg;

	// Single data word
	typedef logic [`WORD_W-1:0] word_t;

	// Full product, or remainder and quotient packed together
	typedef logic [2*`WORD_W-1:0] dword_t;

	// Register index, entry 0 is the hardwired zero register
	typedef logic [`REG_W-1:0] regAddr_t;

	// Operation kind carried with an issued operation
	typedef enum logic {
		OP_MUL = 1'b0,
		OP_DIV = 1'b1
	} opKind_t;

endpackage

// ==== src/mulDiv_consts.svh ====
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// Data word width
`define WORD_W 32

// Register file address width, 32 registers
`define REG_W 5

// One datapath iteration per quotient or multiplier bit
`define MULDIV_ITERS 32

// Accepting edge to resultRdy
// 1 issue stage + MULDIV_ITERS + 1 result stage
`define MULDIV_LATENCY 34

`endif
